// ==== include/gemmx_config.svh ====
`ifndef GEMMX_CONFIG_SVH
`define GEMMX_CONFIG_SVH

// ------------------------------
// Tile geometry
// ------------------------------

// Edge length of a square tile
`define GEMMX_TILE 2

// ------------------------------
// Element widths
// ------------------------------

// A, B and rescaled D elements
`define GEMMX_IN_W 8
// Accumulator, C and raw D elements
`define GEMMX_ACC_W 32

// ------------------------------
// CSR set
// ------------------------------
`define GEMMX_CSR_W 32
`define GEMMX_CSR_RW_COUNT 8
`define GEMMX_CSR_RO_COUNT 2

`endif

// ==== hdl/gemmx_pkg.sv ====
`default_nettype none

`include "gemmx_config.svh"

package gemmx_pkg;

    // ------------------------------
    // Tile types
    // ------------------------------

    // Narrow element, used for A, B and the rescaled output
    typedef logic signed [`GEMMX_IN_W-1:0] elem_in_t;

    // Wide element, used for C, D and the accumulator
    typedef logic signed [`GEMMX_ACC_W-1:0] elem_acc_t;

    // Row-major tiles, element (r, c) sits at index r * TILE + c
    typedef elem_in_t [`GEMMX_TILE*`GEMMX_TILE-1:0] tile_in_t;
    typedef elem_acc_t [`GEMMX_TILE*`GEMMX_TILE-1:0] tile_acc_t;
    typedef elem_in_t [`GEMMX_TILE*`GEMMX_TILE-1:0] tile_out8_t;

    // ------------------------------
    // CSR words
    // ------------------------------
    typedef logic [`GEMMX_CSR_RW_COUNT-1:0][`GEMMX_CSR_W-1:0] csr_rw_t;
    typedef logic [`GEMMX_CSR_RO_COUNT-1:0][`GEMMX_CSR_W-1:0] csr_ro_t;

    // ------------------------------
    // Job configuration
    // ------------------------------

    // GEMM loop bounds and input zero points
    typedef struct packed {
        logic [31:0]        k_count;
        logic [31:0]        n_count;
        logic [31:0]        m_count;
        logic signed [7:0]  a_zp;
        logic signed [7:0]  b_zp;
    } gemm_cfg_t;

    // Rescale parameters and output path select
    typedef struct packed {
        logic signed [31:0] multiplier;
        logic [4:0]         shift;
        logic signed [7:0]  out_zp;
        logic               bypass;
    } simd_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/gemm_job_ctrl.sv ====
`default_nettype none

`include "gemmx_config.svh"

module gemm_job_ctrl
    import gemmx_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  csr_rw_t   csr_set_i,
    input  logic      csr_set_valid_i,
    output logic      csr_set_ready_o,
    output csr_ro_t   csr_ro_o,
    output gemm_cfg_t gemm_cfg_o,
    output simd_cfg_t simd_cfg_o,
    output logic      busy_o,
    output logic      k_last_o,
    input  logic      step_i,
    input  logic      tile_done_i
);

    logic                    busy_q;
    logic                    accept;
    logic                    last_tile;
    logic [31:0]             k_idx_q;
    logic [31:0]             tile_idx_q;
    logic [31:0]             tile_total_q;
    logic [`GEMMX_CSR_W-1:0] perf_cnt_q;
    gemm_cfg_t               gemm_cfg_q;
    simd_cfg_t               simd_cfg_q;

    // New job only while idle
    assign accept          = csr_set_valid_i & ~busy_q;
    assign csr_set_ready_o = ~busy_q;

    assign k_last_o  = (k_idx_q == gemm_cfg_q.k_count - 32'd1);
    assign last_tile = (tile_idx_q == tile_total_q - 32'd1);

    // ------------------------------
    // Config registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gemm_cfg_q   <= '0;
            simd_cfg_q   <= '0;
            tile_total_q <= '0;
        end else if (accept) begin
            gemm_cfg_q.k_count    <= csr_set_i[0];
            gemm_cfg_q.n_count    <= csr_set_i[1];
            gemm_cfg_q.m_count    <= csr_set_i[2];
            gemm_cfg_q.a_zp       <= csr_set_i[3][7:0];
            gemm_cfg_q.b_zp       <= csr_set_i[3][15:8];
            simd_cfg_q.multiplier <= csr_set_i[4];
            simd_cfg_q.shift      <= csr_set_i[5][4:0];
            simd_cfg_q.out_zp     <= csr_set_i[6][7:0];
            simd_cfg_q.bypass     <= csr_set_i[7][0];
            // Output tiles expected for this job
            tile_total_q          <= csr_set_i[1] * csr_set_i[2];
        end
    end

    // ------------------------------
    // Busy and loop counters
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            k_idx_q    <= '0;
            tile_idx_q <= '0;
        end else if (accept) begin
            busy_q     <= 1'b1;
            k_idx_q    <= '0;
            tile_idx_q <= '0;
        end else begin
            if (step_i) begin
                k_idx_q <= k_last_o ? '0 : k_idx_q + 32'd1;
            end
            // Busy drops once the last output tile has left
            if (tile_done_i) begin
                if (last_tile) begin
                    busy_q     <= 1'b0;
                    tile_idx_q <= '0;
                end else begin
                    tile_idx_q <= tile_idx_q + 32'd1;
                end
            end
        end
    end

    // Busy cycle counter, restarted by every new job
    always_ff @(posedge clk_i) begin
        if (reset_i || accept) begin
            perf_cnt_q <= '0;
        end else if (busy_q) begin
            perf_cnt_q <= perf_cnt_q + 1'b1;
        end
    end

    assign csr_ro_o[0] = {{(`GEMMX_CSR_W-1){1'b0}}, busy_q};
    assign csr_ro_o[1] = perf_cnt_q;
    assign gemm_cfg_o  = gemm_cfg_q;
    assign simd_cfg_o  = simd_cfg_q;
    assign busy_o      = busy_q;

endmodule

`default_nettype wire

// ==== hdl/block_gemm_core.sv ====
`default_nettype none

`include "gemmx_config.svh"

module block_gemm_core
    import gemmx_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  gemm_cfg_t gemm_cfg_i,
    input  logic      busy_i,
    input  logic      k_last_i,

    // A stream
    input  tile_in_t  a_i,
    input  logic      a_valid_i,
    output logic      a_ready_o,

    // B stream
    input  tile_in_t  b_i,
    input  logic      b_valid_i,
    output logic      b_ready_o,

    // C stream, consumed on the last K step only
    input  tile_acc_t c_i,
    input  logic      c_valid_i,
    output logic      c_ready_o,

    output logic      step_o,

    // D output register
    output tile_acc_t d_o,
    output logic      d_valid_o,
    input  logic      d_ready_i
);

    tile_acc_t acc_q;
    tile_acc_t acc_next;
    tile_acc_t d_next;
    tile_acc_t d_q;
    logic      d_valid_q;
    logic      d_free;
    logic      advance;
    logic      step;

    // ------------------------------
    // Stream join
    // ------------------------------

    // Hold everything while the finished tile is still waiting
    assign d_free  = ~d_valid_q | d_ready_i;
    assign advance = busy_i & d_free;

    // A and B always, C joins on the last step
    assign step = advance & a_valid_i & b_valid_i & (~k_last_i | c_valid_i);

    assign a_ready_o = step;
    assign b_ready_o = step;
    assign c_ready_o = step & k_last_i;
    assign step_o    = step;

    // ------------------------------
    // Tile product
    // ------------------------------
    always_comb begin : tile_mac
        logic signed [`GEMMX_IN_W:0]    a_diff;
        logic signed [`GEMMX_IN_W:0]    b_diff;
        logic signed [`GEMMX_ACC_W-1:0] dot;
        for (int r = 0; r < `GEMMX_TILE; r++) begin
            for (int c = 0; c < `GEMMX_TILE; c++) begin
                dot = '0;
                for (int k = 0; k < `GEMMX_TILE; k++) begin
                    // One extra bit keeps the zero-point difference exact
                    a_diff = a_i[r*`GEMMX_TILE+k] - gemm_cfg_i.a_zp;
                    b_diff = b_i[k*`GEMMX_TILE+c] - gemm_cfg_i.b_zp;
                    dot    = dot + a_diff * b_diff;
                end
                acc_next[r*`GEMMX_TILE+c] = acc_q[r*`GEMMX_TILE+c] + dot;
                d_next[r*`GEMMX_TILE+c]   = acc_next[r*`GEMMX_TILE+c] + c_i[r*`GEMMX_TILE+c];
            end
        end
    end

    // ------------------------------
    // Accumulator and D register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            acc_q     <= '0;
            d_valid_q <= 1'b0;
        end else begin
            // Accumulator restarts after each finished tile
            if (step) begin
                acc_q <= k_last_i ? '0 : acc_next;
            end
            if (step && k_last_i) begin
                d_valid_q <= 1'b1;
            end else if (d_ready_i) begin
                d_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (step && k_last_i) begin
            d_q <= d_next;
        end
    end

    assign d_o       = d_q;
    assign d_valid_o = d_valid_q;

endmodule

`default_nettype wire

// ==== hdl/rescale_simd.sv ====
`default_nettype none

`include "gemmx_config.svh"

module rescale_simd
    import gemmx_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  simd_cfg_t  simd_cfg_i,

    // D from the core
    input  tile_acc_t  d_i,
    input  logic       d_valid_i,
    output logic       d_ready_o,

    // Raw 32-bit port
    output tile_acc_t  raw_o,
    output logic       raw_valid_o,
    input  logic       raw_ready_i,

    // Rescaled 8-bit port
    output tile_out8_t out8_o,
    output logic       out8_valid_o,
    input  logic       out8_ready_i,

    output logic       tile_done_o
);

    tile_out8_t out8_next;
    tile_out8_t out8_q;
    logic       out8_valid_q;
    logic       out8_free;
    logic       bypass;
    logic       load;

    // Multiply, shift, add zero point, then saturate
    function automatic elem_in_t rescale_elem(input elem_acc_t value, input simd_cfg_t cfg);
        logic signed [63:0] product;
        logic signed [63:0] shifted;
        logic signed [63:0] biased;
        logic signed [63:0] max_val;
        logic signed [63:0] min_val;
        max_val = (64'sd1 <<< (`GEMMX_IN_W - 1)) - 64'sd1;
        min_val = -(64'sd1 <<< (`GEMMX_IN_W - 1));
        product = value * cfg.multiplier;
        // Truncating shift, no rounding
        shifted = product >>> cfg.shift;
        biased  = shifted + cfg.out_zp;
        if (biased > max_val) begin
            return max_val[`GEMMX_IN_W-1:0];
        end else if (biased < min_val) begin
            return min_val[`GEMMX_IN_W-1:0];
        end
        return biased[`GEMMX_IN_W-1:0];
    endfunction

    // ------------------------------
    // Path select
    // ------------------------------
    assign bypass    = simd_cfg_i.bypass;
    assign out8_free = ~out8_valid_q | out8_ready_i;

    assign raw_o       = d_i;
    assign raw_valid_o = d_valid_i & bypass;
    assign d_ready_o   = bypass ? raw_ready_i : out8_free;
    assign load        = d_valid_i & ~bypass & out8_free;

    // ------------------------------
    // Rescale stage
    // ------------------------------
    always_comb begin
        for (int i = 0; i < `GEMMX_TILE * `GEMMX_TILE; i++) begin
            out8_next[i] = rescale_elem(d_i[i], simd_cfg_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out8_valid_q <= 1'b0;
        end else if (load) begin
            out8_valid_q <= 1'b1;
        end else if (out8_ready_i) begin
            out8_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out8_q <= out8_next;
        end
    end

    assign out8_o       = out8_q;
    assign out8_valid_o = out8_valid_q;

    // One finished tile left on either port
    assign tile_done_o = (raw_valid_o & raw_ready_i) | (out8_valid_q & out8_ready_i);

endmodule

`default_nettype wire

// ==== hdl/gemmx_shell_wrapper.sv ====
`default_nettype none

module gemmx_shell_wrapper
    import gemmx_pkg::*;
(
    // ------------------------------
    // Clock and reset
    // ------------------------------
    input  logic       clk_i,
    input  logic       reset_i,

    // ------------------------------
    // Streamer ports
    // ------------------------------

    // Accelerator to streamer, rescaled and raw D
    output tile_out8_t acc2stream_0_data_o,
    output logic       acc2stream_0_valid_o,
    input  logic       acc2stream_0_ready_i,

    output tile_acc_t  acc2stream_1_data_o,
    output logic       acc2stream_1_valid_o,
    input  logic       acc2stream_1_ready_i,

    // Streamer to accelerator, A, B and C
    input  tile_in_t   stream2acc_0_data_i,
    input  logic       stream2acc_0_valid_i,
    output logic       stream2acc_0_ready_o,

    input  tile_in_t   stream2acc_1_data_i,
    input  logic       stream2acc_1_valid_i,
    output logic       stream2acc_1_ready_o,

    input  tile_acc_t  stream2acc_2_data_i,
    input  logic       stream2acc_2_valid_i,
    output logic       stream2acc_2_ready_o,

    // ------------------------------
    // CSR manager ports
    // ------------------------------
    input  csr_rw_t    csr_reg_set_i,
    input  logic       csr_reg_set_valid_i,
    output logic       csr_reg_set_ready_o,
    output csr_ro_t    csr_reg_ro_set_o
);

    gemm_cfg_t gemm_cfg;
    simd_cfg_t simd_cfg;
    logic      busy;
    logic      k_last;
    logic      step;
    tile_acc_t d_tile;
    logic      d_valid;
    logic      d_ready;
    logic      tile_done;

    gemm_job_ctrl i_job_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .csr_set_i       (csr_reg_set_i),
        .csr_set_valid_i (csr_reg_set_valid_i),
        .csr_set_ready_o (csr_reg_set_ready_o),
        .csr_ro_o        (csr_reg_ro_set_o),
        .gemm_cfg_o      (gemm_cfg),
        .simd_cfg_o      (simd_cfg),
        .busy_o          (busy),
        .k_last_o        (k_last),
        .step_i          (step),
        .tile_done_i     (tile_done)
    );

    block_gemm_core i_gemm_core (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .gemm_cfg_i (gemm_cfg),
        .busy_i     (busy),
        .k_last_i   (k_last),
        .a_i        (stream2acc_0_data_i),
        .a_valid_i  (stream2acc_0_valid_i),
        .a_ready_o  (stream2acc_0_ready_o),
        .b_i        (stream2acc_1_data_i),
        .b_valid_i  (stream2acc_1_valid_i),
        .b_ready_o  (stream2acc_1_ready_o),
        .c_i        (stream2acc_2_data_i),
        .c_valid_i  (stream2acc_2_valid_i),
        .c_ready_o  (stream2acc_2_ready_o),
        .step_o     (step),
        .d_o        (d_tile),
        .d_valid_o  (d_valid),
        .d_ready_i  (d_ready)
    );

    // Output stage feeds both streamer ports
    rescale_simd i_rescale (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .simd_cfg_i   (simd_cfg),
        .d_i          (d_tile),
        .d_valid_i    (d_valid),
        .d_ready_o    (d_ready),
        .raw_o        (acc2stream_1_data_o),
        .raw_valid_o  (acc2stream_1_valid_o),
        .raw_ready_i  (acc2stream_1_ready_i),
        .out8_o       (acc2stream_0_data_o),
        .out8_valid_o (acc2stream_0_valid_o),
        .out8_ready_i (acc2stream_0_ready_i),
        .tile_done_o  (tile_done)
    );

endmodule

`default_nettype wire

// ==== tests/gemmx_assert.sv ====
`default_nettype none

module gemmx_assert
    import gemmx_pkg::*;
(
    input logic       clk_i,
    input logic       reset_i,
    input tile_out8_t out8_data_i,
    input logic       out8_valid_i,
    input logic       out8_ready_i,
    input tile_acc_t  raw_data_i,
    input logic       raw_valid_i,
    input logic       raw_ready_i,
    input logic       csr_valid_i,
    input logic       csr_ready_i,
    input csr_ro_t    ro_set_i
);

    // Number of failed assertions
    int fail_count;

    initial fail_count = 0;

    // ------------------------------
    // Output handshakes
    // ------------------------------
    raw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        raw_valid_i && !raw_ready_i |=> raw_valid_i && $stable(raw_data_i))
    else begin
        $error("raw output dropped or changed while stalled");
        fail_count++;
    end

    out8_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        out8_valid_i && !out8_ready_i |=> out8_valid_i && $stable(out8_data_i))
    else begin
        $error("8-bit output dropped or changed while stalled");
        fail_count++;
    end

    // ------------------------------
    // Busy flag
    // ------------------------------
    idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !ro_set_i[0][0])
    else begin
        $error("busy set in the cycle after reset");
        fail_count++;
    end

    // A config transfer starts the job and closes CSR ready
    accept_starts_job: assert property (@(posedge clk_i) disable iff (reset_i)
        csr_valid_i && csr_ready_i |=> ro_set_i[0][0] && !csr_ready_i)
    else begin
        $error("config transfer did not set busy and clear CSR ready");
        fail_count++;
    end

endmodule

bind gemmx_shell_wrapper gemmx_assert i_assert (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .out8_data_i  (acc2stream_0_data_o),
    .out8_valid_i (acc2stream_0_valid_o),
    .out8_ready_i (acc2stream_0_ready_i),
    .raw_data_i   (acc2stream_1_data_o),
    .raw_valid_i  (acc2stream_1_valid_o),
    .raw_ready_i  (acc2stream_1_ready_i),
    .csr_valid_i  (csr_reg_set_valid_i),
    .csr_ready_i  (csr_reg_set_ready_o),
    .ro_set_i     (csr_reg_ro_set_o)
);

`default_nettype wire

// ==== tests/gemmx_tb.sv ====
`default_nettype none

`include "gemmx_config.svh"

module gemmx_tb
    import gemmx_pkg::*;
();

    localparam int ELEMS = `GEMMX_TILE * `GEMMX_TILE;
    // Output tiles over all jobs below
    localparam int TILE_COUNT = 20;
    localparam int WATCHDOG_CYCLES = TILE_COUNT * 20 + 200;

    logic       clk;
    logic       reset;
    tile_in_t   a_data;
    logic       a_valid;
    logic       a_ready;
    tile_in_t   b_data;
    logic       b_valid;
    logic       b_ready;
    tile_acc_t  c_data;
    logic       c_valid;
    logic       c_ready;
    tile_out8_t out8_data;
    logic       out8_valid;
    logic       out8_ready;
    tile_acc_t  raw_data;
    logic       raw_valid;
    logic       raw_ready;
    csr_rw_t    csr_set;
    logic       csr_valid;
    logic       csr_ready;
    csr_ro_t    ro_set;
    integer     seed;

    // Stimulus of the current job and the expected results
    tile_in_t   a_q[$];
    tile_in_t   b_q[$];
    tile_acc_t  c_q[$];
    tile_acc_t  raw_exp_q[$];
    tile_out8_t out8_exp_q[$];
    csr_rw_t    cfg_words;

    gemmx_shell_wrapper i_dut (
        .clk_i                (clk),
        .reset_i              (reset),
        .acc2stream_0_data_o  (out8_data),
        .acc2stream_0_valid_o (out8_valid),
        .acc2stream_0_ready_i (out8_ready),
        .acc2stream_1_data_o  (raw_data),
        .acc2stream_1_valid_o (raw_valid),
        .acc2stream_1_ready_i (raw_ready),
        .stream2acc_0_data_i  (a_data),
        .stream2acc_0_valid_i (a_valid),
        .stream2acc_0_ready_o (a_ready),
        .stream2acc_1_data_i  (b_data),
        .stream2acc_1_valid_i (b_valid),
        .stream2acc_1_ready_o (b_ready),
        .stream2acc_2_data_i  (c_data),
        .stream2acc_2_valid_i (c_valid),
        .stream2acc_2_ready_o (c_ready),
        .csr_reg_set_i        (csr_set),
        .csr_reg_set_valid_i  (csr_valid),
        .csr_reg_set_ready_o  (csr_ready),
        .csr_reg_ro_set_o     (ro_set)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("mismatch at time %0t: %s", $time, msg));
    endtask

    task automatic compare_acc(input tile_acc_t got, input tile_acc_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic compare_out8(input tile_out8_t got, input tile_out8_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic compare_csr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Zero-point corrected 2x2 product, row-major
    function automatic tile_acc_t tile_product(input tile_in_t a, input tile_in_t b);
        logic signed [7:0] a_zp;
        logic signed [7:0] b_zp;
        int                sum;
        tile_acc_t         p;
        a_zp = cfg_words[3][7:0];
        b_zp = cfg_words[3][15:8];
        for (int r = 0; r < `GEMMX_TILE; r++) begin
            for (int c = 0; c < `GEMMX_TILE; c++) begin
                sum = 0;
                for (int k = 0; k < `GEMMX_TILE; k++) begin
                    sum += (int'(a[r*`GEMMX_TILE+k]) - a_zp) *
                           (int'(b[k*`GEMMX_TILE+c]) - b_zp);
                end
                p[r*`GEMMX_TILE+c] = sum;
            end
        end
        return p;
    endfunction

    function automatic tile_out8_t rescale_tile(input tile_acc_t d);
        tile_out8_t        q;
        longint            v;
        logic signed [7:0] zp;
        zp = cfg_words[6][7:0];
        for (int e = 0; e < ELEMS; e++) begin
            v = longint'(d[e]) * longint'(signed'(cfg_words[4]));
            v = v >>> cfg_words[5][4:0];
            v = v + zp;
            if (v > 127) begin
                v = 127;
            end else if (v < -128) begin
                v = -128;
            end
            q[e] = v[7:0];
        end
        return q;
    endfunction

    task automatic build_expected();
        int        k;
        int        tiles;
        tile_acc_t sum;
        tile_acc_t prod;
        raw_exp_q.delete();
        out8_exp_q.delete();
        k     = cfg_words[0];
        tiles = cfg_words[1] * cfg_words[2];
        for (int t = 0; t < tiles; t++) begin
            sum = c_q[t];
            for (int s = 0; s < k; s++) begin
                prod = tile_product(a_q[t*k+s], b_q[t*k+s]);
                for (int e = 0; e < ELEMS; e++) begin
                    sum[e] = sum[e] + prod[e];
                end
            end
            if (cfg_words[7][0]) begin
                raw_exp_q.push_back(sum);
            end else begin
                out8_exp_q.push_back(rescale_tile(sum));
            end
        end
    endtask

    // ------------------------------
    // Job setup
    // ------------------------------
    function automatic csr_rw_t make_words(input int k, n, m, a_zp, b_zp, mult, shift,
                                           out_zp, input bit bypass);
        csr_rw_t w;
        w    = '0;
        w[0] = k;
        w[1] = n;
        w[2] = m;
        w[3] = {16'h0, b_zp[7:0], a_zp[7:0]};
        w[4] = mult;
        w[5] = shift;
        w[6] = {24'h0, out_zp[7:0]};
        w[7] = {31'h0, bypass};
        return w;
    endfunction

    function automatic tile_in_t random_in_tile();
        tile_in_t t;
        for (int e = 0; e < ELEMS; e++) begin
            t[e] = $random(seed);
        end
        return t;
    endfunction

    task automatic load_inputs(input csr_rw_t w);
        tile_acc_t c;
        cfg_words = w;
        a_q.delete();
        b_q.delete();
        c_q.delete();
        for (int s = 0; s < w[0] * w[1] * w[2]; s++) begin
            a_q.push_back(random_in_tile());
            b_q.push_back(random_in_tile());
        end
        for (int t = 0; t < w[1] * w[2]; t++) begin
            for (int e = 0; e < ELEMS; e++) begin
                c[e] = $random(seed) % 100000;
            end
            c_q.push_back(c);
        end
    endtask

    // ------------------------------
    // Stream drivers and monitor
    // ------------------------------

    // Called one unit after a rising edge, returns at the same point
    task automatic send_cfg(input csr_rw_t w);
        csr_set   = w;
        csr_valid = 1'b1;
        do @(posedge clk); while (!csr_ready);
        #1;
        csr_valid = 1'b0;
    endtask

    task automatic feed_ab();
        for (int i = 0; i < a_q.size(); i++) begin
            a_data  = a_q[i];
            b_data  = b_q[i];
            a_valid = 1'b1;
            b_valid = 1'b1;
            do @(posedge clk); while (!(a_ready && b_ready));
            #1;
        end
        a_valid = 1'b0;
        b_valid = 1'b0;
    endtask

    task automatic feed_c();
        for (int i = 0; i < c_q.size(); i++) begin
            c_data  = c_q[i];
            c_valid = 1'b1;
            do @(posedge clk); while (!c_ready);
            #1;
        end
        c_valid = 1'b0;
    endtask

    task automatic watch_outputs(input bit stall);
        int seen;
        int total;
        int stretch;
        bit bypass;
        seen    = 0;
        stretch = 0;
        bypass  = cfg_words[7][0];
        total   = bypass ? raw_exp_q.size() : out8_exp_q.size();
        while (seen < total) begin
            @(posedge clk);
            if (bypass && out8_valid) begin
                abort_run("the 8-bit port became valid while the raw path was selected");
            end
            if (!bypass && raw_valid) begin
                abort_run("the raw port became valid while the rescale path was selected");
            end
            if (raw_valid && raw_ready) begin
                compare_acc(raw_data, raw_exp_q.pop_front(), $sformatf("raw tile %0d", seen));
                seen++;
            end
            if (out8_valid && out8_ready) begin
                compare_out8(out8_data, out8_exp_q.pop_front(), $sformatf("int8 tile %0d", seen));
                seen++;
            end
            #1;
            // Ready alternates in random stretches of one to eight cycles
            if (stall) begin
                if (stretch == 0) begin
                    stretch    = ($random(seed) & 7) + 1;
                    raw_ready  = ~raw_ready;
                    out8_ready = raw_ready;
                end
                stretch--;
            end
        end
        raw_ready  = 1'b1;
        out8_ready = 1'b1;
    endtask

    task automatic stream_tiles(input bit stall);
        fork
            feed_ab();
            feed_c();
            watch_outputs(stall);
        join
    endtask

    // Right after the last output, busy is low and the counter covers every K step
    task automatic check_idle();
        int steps;
        steps = cfg_words[0] * cfg_words[1] * cfg_words[2];
        compare_csr(ro_set[0], 32'd0, "busy after the last tile");
        if (ro_set[1] < steps) begin
            report_mismatch($sformatf("busy counter %0d below %0d K steps", ro_set[1], steps));
        end
    endtask

    task automatic execute_job(input bit stall);
        build_expected();
        send_cfg(cfg_words);
        stream_tiles(stall);
        check_idle();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic check_reset_state();
        @(posedge clk);
        compare_csr(ro_set[0], 32'd0, "RO busy word after reset");
        compare_csr(ro_set[1], 32'd0, "busy counter after reset");
        compare_csr({31'h0, csr_ready}, 32'd1, "CSR ready after reset");
        if (raw_valid || out8_valid) begin
            abort_run("an output valid is high after reset");
        end
        if (a_ready || b_ready || c_ready) begin
            abort_run("an input stream ready is high after reset");
        end
        #1;
    endtask

    task automatic raw_path_job();
        load_inputs(make_words(1, 1, 1, 3, -2, 1, 0, 0, 1'b1));
        execute_job(1'b0);
    endtask

    task automatic accumulate_over_k();
        load_inputs(make_words(3, 1, 2, -5, 7, 1, 0, 0, 1'b1));
        execute_job(1'b0);
    endtask

    task automatic rescale_saturation();
        load_inputs(make_words(2, 2, 2, 4, -3, 3, 10, 5, 1'b0));
        // Far beyond the int8 range on both sides
        c_q[0][0] = 32'sd2000000;
        c_q[0][1] = -32'sd2000000;
        execute_job(1'b0);
    endtask

    task automatic output_back_pressure();
        load_inputs(make_words(2, 3, 2, 1, 2, 1, 0, 0, 1'b1));
        execute_job(1'b1);
        load_inputs(make_words(2, 2, 2, -1, 0, 5, 3, -4, 1'b0));
        execute_job(1'b1);
    endtask

    task automatic busy_and_counter();
        csr_rw_t next_words;
        next_words = make_words(1, 1, 1, 0, 0, 1, 0, 0, 1'b1);
        load_inputs(make_words(4, 2, 1, 1, -1, 1, 0, 0, 1'b1));
        build_expected();
        send_cfg(cfg_words);
        // Second config waits until the running job is done
        csr_set   = next_words;
        csr_valid = 1'b1;
        repeat (3) begin
            @(posedge clk);
            compare_csr({31'h0, csr_ready}, 32'd0, "CSR ready during a job");
            compare_csr(ro_set[0], 32'd1, "RO busy word during a job");
            #1;
        end
        stream_tiles(1'b0);
        check_idle();
        do @(posedge clk); while (!csr_ready);
        #1;
        csr_valid = 1'b0;
        load_inputs(next_words);
        build_expected();
        stream_tiles(1'b0);
        check_idle();
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        seed       = 32'hc950_dd21;
        reset      = 1'b1;
        a_data     = '0;
        a_valid    = 1'b0;
        b_data     = '0;
        b_valid    = 1'b0;
        c_data     = '0;
        c_valid    = 1'b0;
        raw_ready  = 1'b1;
        out8_ready = 1'b1;
        csr_set    = '0;
        csr_valid  = 1'b0;
        cfg_words  = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        raw_path_job();
        accumulate_over_k();
        rescale_saturation();
        output_back_pressure();
        busy_and_counter();
        if (i_dut.i_assert.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("bound assertions reported errors during the run");
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, the tests did not finish within the cycle limit");
    end

endmodule

`default_nettype wire

// ==== gemmx_shell.f ====
+incdir+include
hdl/gemmx_pkg.sv
hdl/gemm_job_ctrl.sv
hdl/block_gemm_core.sv
hdl/rescale_simd.sv
hdl/gemmx_shell_wrapper.sv
tests/gemmx_assert.sv
tests/gemmx_tb.sv
